/* tb.f */
+incdir+dv
hw/asg_pkg.sv
hw/asg_apb_pkg.sv
hw/asg_apb_regs.sv
hw/asg_ext_trig.sv
hw/asg_burst_fsm.sv
hw/asg_wave_table.sv
hw/asg_scale_sat.sv
hw/asg_channel.sv
dv/asg_channel_tb.sv

/* Bender.yml */
package:
  name: asg_channel

sources:
  - target: rtl
    files:
      - hw/asg_pkg.sv
      - hw/asg_apb_pkg.sv
      - hw/asg_apb_regs.sv
      - hw/asg_ext_trig.sv
      - hw/asg_burst_fsm.sv
      - hw/asg_wave_table.sv
      - hw/asg_scale_sat.sv
      - hw/asg_channel.sv

  - target: test
    include_dirs:
      - dv
    files:
      - dv/asg_channel_tb.sv

/* dv/asg_tb_vectors.svh */
`ifndef ASG_TB_VECTORS_SVH
`define ASG_TB_VECTORS_SVH

// columns: fill, amp, dc, last, ncyc, rnum, src, noise, expected dac_o
// continuous rows expect sat((fill * amp) >>> 13 + dc), burst rows expect last

typedef struct packed {
  sample_t             fill;   // constant over the played words
  logic [SAMPLE_W-1:0] amp;    // 0x2000 is unity
  sample_t             dc;
  sample_t             last;
  cnt16_t              ncyc;
  cnt16_t              rnum;
  trig_src_e           src;
  logic                noise;  // random words outside the played range
  sample_t             want;   // steady dac_o
} vec_row_t;

localparam int unsigned N_ROWS = 9;

localparam vec_row_t ROWS [N_ROWS] = '{
  // continuous mode, started by software, runs until the next reset
  '{14'h0123, 14'h2000, 14'h0000, 14'h0000, 16'd0, 16'd0, TRIG_SW,      1'b0, 14'h0123},
  '{14'h0800, 14'h1000, 14'h0010, 14'h0000, 16'd0, 16'd0, TRIG_SW,      1'b0, 14'h0410},
  '{14'h3f00, 14'h2000, 14'h3ff0, 14'h0000, 16'd0, 16'd0, TRIG_SW,      1'b1, 14'h3ef0},
  '{14'h3fff, 14'h1000, 14'h0000, 14'h0000, 16'd0, 16'd0, TRIG_SW,      1'b0, 14'h3fff},
  // saturation, both rails
  '{14'h1000, 14'h3fff, 14'h1000, 14'h0000, 16'd0, 16'd0, TRIG_SW,      1'b0, 14'h1fff},
  '{14'h2000, 14'h3fff, 14'h3000, 14'h0000, 16'd0, 16'd0, TRIG_SW,      1'b1, 14'h2000},
  // two-cycle bursts ending on the last value
  '{14'h0100, 14'h2000, 14'h0000, 14'h0abc, 16'd2, 16'd0, TRIG_SW,      1'b1, 14'h0abc},
  '{14'h0200, 14'h1000, 14'h0005, 14'h3c00, 16'd2, 16'd0, TRIG_SW,      1'b0, 14'h3c00},
  '{14'h0040, 14'h2000, 14'h0010, 14'h1234, 16'd2, 16'd0, TRIG_EXT_POS, 1'b1, 14'h1234}
};

`endif

/* dv/asg_channel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_channel_tb import asg_pkg::*, asg_apb_pkg::*; ();

  `include "asg_tb_vectors.svh"

  localparam int unsigned TBL_LEN    = 16;   // played words
  localparam int unsigned NOISE_LEN  = 16;   // words after them
  localparam int unsigned SETTLE_MAX = 200;
  localparam int unsigned STEADY_CYC = 64;   // longer than one table pass

  // register map check: write value, implemented bits
  localparam int unsigned N_REGS = 9;
  localparam apb_addr_t REG_ADDR [N_REGS] = '{REG_CTRL, REG_AMP_DC, REG_SIZE, REG_OFS,
                                              REG_STEP, REG_LAST, REG_NCYC, REG_RNUM, REG_RDLY};
  localparam logic [31:0] REG_WDATA [N_REGS] = '{32'h0000_00ba, 32'hc5a5_e123, 32'hfc12_3456,
                                                 32'h0abc_def0, 32'h1357_9bdf, 32'h0001_f00d,
                                                 32'habcd_1234, 32'h0000_8001, 32'h8765_4321};
  localparam logic [31:0] REG_MASK [N_REGS] = '{32'h0000_007f, 32'h3fff_3fff, 32'h03ff_ffff,
                                                32'h03ff_ffff, 32'h03ff_ffff, 32'h0000_3fff,
                                                32'h0000_ffff, 32'h0000_ffff, 32'hffff_ffff};

  logic        dac_clk = 1'b0;
  logic        dac_rstn;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        trig_ext;
  logic        trig_done;
  sample_t     dac;
  integer      seed = 32'hd2a3_8f93;  // noise words
  int unsigned done_cnt = 0;          // trig_done_o pulses seen

  asg_channel dut_i (
    .dac_clk_i   (dac_clk),
    .dac_rstn_i  (dac_rstn),
    .apb_req_i   (apb_req),
    .apb_rsp_o   (apb_rsp),
    .trig_ext_i  (trig_ext),
    .trig_done_o (trig_done),
    .dac_o       (dac)
  );

  always #10 dac_clk = ~dac_clk;  // 50 MHz

  always @(posedge dac_clk) begin
    if (!dac_rstn) done_cnt <= 0;
    else if (trig_done) done_cnt <= done_cnt + 1;
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge dac_clk);
    #2;  // drive and sample away from the edge
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic apb_write(input apb_addr_t addr, input logic [31:0] data);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    next_cycle();              // setup
    apb_req.penable = 1'b1;
    next_cycle();              // access, write lands on this edge
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output logic [31:0] data, output logic err);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
    apb_req.paddr   = addr;
    next_cycle();
    apb_req.penable = 1'b1;
    #1;                        // comb read path
    data = apb_rsp.prdata;
    err  = apb_rsp.pslverr;
    next_cycle();
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic wait_done(input int unsigned target, input int unsigned limit,
                           input string what);
    int unsigned n;
    n = 0;
    while ((done_cnt < target) && (n < limit)) begin
      next_cycle();
      n++;
    end
    assert (done_cnt >= target) else
      abort_run($sformatf("timeout in wait_done: no trig_done_o pulse after %s", what));
  endtask

  task automatic settle_dac(input sample_t want);
    int unsigned n;
    n = 0;
    while ((dac !== want) && (n < SETTLE_MAX)) begin
      next_cycle();
      n++;
    end
    assert (dac === want) else
      abort_run($sformatf("FAILED dac_o: expected %h, got %h (settle_dac timed out)",
                          want, dac));
  endtask

  task automatic check_steady(input sample_t want, input int unsigned ncyc);
    int unsigned n;
    for (n = 0; n < ncyc; n++) begin
      next_cycle();
      assert (dac === want) else
        abort_run($sformatf("FAILED dac_o: expected %h, got %h, %0d cycles after settling",
                            want, dac, n));
    end
  endtask

  // ------------------------------------------------------------------
  // register bank
  // ------------------------------------------------------------------
  task automatic check_regs();
    logic [31:0] rdata;
    logic        err;
    int          i;
    for (i = 0; i < N_REGS; i++) apb_write(REG_ADDR[i], REG_WDATA[i]);
    for (i = 0; i < N_REGS; i++) begin
      apb_read(REG_ADDR[i], rdata, err);
      assert (rdata === (REG_WDATA[i] & REG_MASK[i])) else
        abort_run($sformatf("FAILED apb_rsp_o.prdata at %h: expected %h, got %h",
                            REG_ADDR[i], REG_WDATA[i] & REG_MASK[i], rdata));
      assert (err === 1'b0) else
        abort_run($sformatf("FAILED apb_rsp_o.pslverr at %h: expected 0, got %h",
                            REG_ADDR[i], err));
    end
    apb_read(20'h00024, rdata, err);  // first hole after the map
    assert (err === 1'b1) else
      abort_run($sformatf("FAILED apb_rsp_o.pslverr at 00024: expected 1, got %h", err));
  endtask

  task automatic fill_table(input sample_t fill, input logic noise);
    int          i;
    logic [31:0] rnd;
    sample_t     word;
    for (i = 0; i < TBL_LEN + NOISE_LEN; i++) begin
      rnd  = $random(seed);
      word = fill;
      if (i >= TBL_LEN) word = noise ? rnd[SAMPLE_W-1:0] : 14'h0;  // never played
      apb_write(TBL_BASE + apb_addr_t'(i << 2), {18'h0, word});
    end
  endtask

  // rising edge, a bounce inside the hold-off, then the pin stays high
  task automatic ext_rise_burst(input int unsigned base);
    int unsigned n;
    trig_ext = 1'b1;
    wait_done(base + 1, 16, "the external rising edge");
    repeat (40) next_cycle();
    trig_ext = 1'b0;
    repeat (8) next_cycle();
    trig_ext = 1'b1;  // second edge, must be swallowed
    for (n = 0; n < DEBOUNCE_CYCLES + 100; n++) begin
      next_cycle();
    end
  endtask

  // ------------------------------------------------------------------
  // one vector row
  // ------------------------------------------------------------------
  task automatic run_row(input int unsigned idx);
    vec_row_t    row;
    logic [31:0] ctrl;
    int unsigned base;
    int unsigned pulses;
    row    = ROWS[idx];
    ctrl   = {24'h0, 1'b0, row.src, 1'b0, 1'b0, 1'b1, 1'b0};  // wrap on
    pulses = (row.src == TRIG_NONE) ? 0 : 1;
    apb_write(REG_CTRL, ctrl | 32'h1);  // channel reset clears the hold
    fill_table(row.fill, row.noise);
    apb_write(REG_AMP_DC, {2'b00, row.dc, 2'b00, row.amp});
    apb_write(REG_SIZE, (TBL_LEN << PNT_FRAC_W) - 1);
    apb_write(REG_OFS, 32'h0);
    apb_write(REG_STEP, 32'h1 << PNT_FRAC_W);  // one word per cycle
    apb_write(REG_LAST, {18'h0, row.last});
    apb_write(REG_NCYC, {16'h0, row.ncyc});
    apb_write(REG_RNUM, {16'h0, row.rnum});
    apb_write(REG_RDLY, 32'h0);
    apb_write(REG_CTRL, ctrl);
    base = done_cnt;
    case (row.src)
      TRIG_SW: begin
        apb_write(REG_CTRL, ctrl | 32'h80);
        wait_done(base + 1, 16, "the software trigger");
      end
      TRIG_EXT_POS: ext_rise_burst(base);
      default: ;
    endcase
    settle_dac(row.want);
    check_steady(row.want, STEADY_CYC);
    assert (done_cnt == base + pulses) else
      abort_run($sformatf("FAILED trig_done_o pulse count in row %0d: expected %h, got %h",
                          idx, pulses, done_cnt - base));
    // zero beats everything, then the old value comes back
    apb_write(REG_CTRL, ctrl | 32'h4);
    settle_dac(14'h0);
    check_steady(14'h0, 16);
    apb_write(REG_CTRL, ctrl);
    settle_dac(row.want);
    check_steady(row.want, 16);
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int unsigned r;
    dac_rstn = 1'b0;
    apb_req  = '0;
    trig_ext = 1'b0;
    repeat (8) next_cycle();
    assert (dac === 14'h0) else
      abort_run($sformatf("FAILED dac_o after reset: expected 0000, got %h", dac));
    assert (trig_done === 1'b0) else
      abort_run($sformatf("FAILED trig_done_o after reset: expected 0, got %h", trig_done));
    dac_rstn = 1'b1;
    next_cycle();

    check_regs();
    for (r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/asg_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_channel import asg_pkg::*, asg_apb_pkg::*; (
  input  wire       dac_clk_i,
  input  wire       dac_rstn_i,
  input  wire  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o,
  input  wire       trig_ext_i,
  output logic      trig_done_o,
  output sample_t   dac_o
);

  burst_cfg_t        burst_cfg;
  out_cfg_t          out_cfg;
  tbl_wr_t           tbl_wr;
  logic              trig_sw;
  logic              trig_pos;
  logic              trig_neg;
  logic [TBL_AW-1:0] rd_addr;
  sample_t           rd_data;
  logic              hold_last;

  // ------------------------------------------------------------------
  // control side
  // ------------------------------------------------------------------
  asg_apb_regs regs_i (
    .dac_clk_i   (dac_clk_i),
    .dac_rstn_i  (dac_rstn_i),
    .apb_req_i   (apb_req_i),
    .apb_rsp_o   (apb_rsp_o),
    .burst_cfg_o (burst_cfg),
    .out_cfg_o   (out_cfg),
    .trig_sw_o   (trig_sw),
    .tbl_wr_o    (tbl_wr)
  );

  asg_ext_trig ext_trig_i (
    .dac_clk_i  (dac_clk_i),
    .dac_rstn_i (dac_rstn_i),
    .trig_ext_i (trig_ext_i),
    .trig_pos_o (trig_pos),
    .trig_neg_o (trig_neg)
  );

  asg_burst_fsm fsm_i (
    .dac_clk_i   (dac_clk_i),
    .dac_rstn_i  (dac_rstn_i),
    .burst_cfg_i (burst_cfg),
    .trig_sw_i   (trig_sw),
    .trig_pos_i  (trig_pos),
    .trig_neg_i  (trig_neg),
    .trig_ext_i  (trig_ext_i),  // raw level for gating
    .trig_done_o (trig_done_o),
    .rd_addr_o   (rd_addr),
    .hold_last_o (hold_last)
  );

  // sample path, 2 + 3 cycles
  asg_wave_table table_i (
    .dac_clk_i (dac_clk_i),
    .tbl_wr_i  (tbl_wr),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  asg_scale_sat scale_i (
    .dac_clk_i   (dac_clk_i),
    .dac_rstn_i  (dac_rstn_i),
    .sample_i    (rd_data),
    .out_cfg_i   (out_cfg),
    .hold_last_i (hold_last),
    .dac_o       (dac_o)
  );

endmodule

`default_nettype wire

/* hw/asg_scale_sat.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_scale_sat import asg_pkg::*; (
  input  wire             dac_clk_i,
  input  wire             dac_rstn_i,
  input  wire  sample_t   sample_i,
  input  wire  out_cfg_t  out_cfg_i,
  input  wire             hold_last_i,  // already pipeline aligned
  output sample_t         dac_o
);

  logic signed [2*SAMPLE_W-1:0] mult_q;
  logic signed [SAMPLE_W+1:0]   sum_q;   // two guard bits
  out_cfg_t                     cfg_q1;  // cfg follows the sample
  out_cfg_t                     cfg_q2;
  logic                         ovf;

  // stage 1 and 2, gain then offset
  always_ff @(posedge dac_clk_i) begin
    mult_q <= sample_i * $signed({1'b0, out_cfg_i.amp});
    sum_q  <= $signed(mult_q[2*SAMPLE_W-1:SAMPLE_W-1]) + $signed(cfg_q1.dc);  // >>13
  end

  // out of range when the top three bits disagree
  assign ovf = (sum_q[SAMPLE_W+1:SAMPLE_W-1] != 3'b000) &&
               (sum_q[SAMPLE_W+1:SAMPLE_W-1] != 3'b111);

  // ------------------------------------------------------------------
  // stage 3, overrides and saturation
  // ------------------------------------------------------------------
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      cfg_q1 <= '0;
      cfg_q2 <= '0;
      dac_o  <= '0;
    end else begin
      cfg_q1 <= out_cfg_i;
      cfg_q2 <= cfg_q1;
      if (cfg_q2.zero) begin
        dac_o <= '0;
      end else if (hold_last_i) begin
        dac_o <= cfg_q2.last;
      end else if (ovf) begin
        dac_o <= {sum_q[SAMPLE_W+1], {(SAMPLE_W-1){~sum_q[SAMPLE_W+1]}}};  // 1fff / 2000
      end else begin
        dac_o <= sum_q[SAMPLE_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* hw/asg_wave_table.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_wave_table import asg_pkg::*; (
  input  wire               dac_clk_i,
  input  wire  tbl_wr_t     tbl_wr_i,
  input  wire  [TBL_AW-1:0] rd_addr_i,
  output sample_t           rd_data_o
);

  sample_t mem [2**TBL_AW];
  sample_t rd_q;  // ram output

  always_ff @(posedge dac_clk_i) begin
    if (tbl_wr_i.we) begin
      mem[tbl_wr_i.addr] <= tbl_wr_i.data;
    end
    rd_q      <= mem[rd_addr_i];
    rd_data_o <= rd_q;  // extra stage for timing
  end

endmodule

`default_nettype wire

/* hw/asg_burst_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_burst_fsm import asg_pkg::*; (
  input  wire               dac_clk_i,
  input  wire               dac_rstn_i,
  input  wire  burst_cfg_t  burst_cfg_i,
  input  wire               trig_sw_i,
  input  wire               trig_pos_i,
  input  wire               trig_neg_i,
  input  wire               trig_ext_i,   // raw level, gated repetition
  output logic              trig_done_o,
  output logic [TBL_AW-1:0] rd_addr_o,
  output logic              hold_last_o
);

  logic                trig_q;      // selected trigger
  logic                play_q;      // stepping through the table
  logic                rep_q;       // repetition mode
  logic                start;       // burst or repetition begins
  logic                start_q;
  logic                cont;        // continuous mode
  logic                gate_drop;   // gate level lost
  logic                tick;
  logic [TICK_W-1:0]   tick_q;
  cnt16_t              cyc_q;
  cnt16_t              rep_cnt_q;
  dly_t                dly_q;
  pnt_t                pnt_q;
  pnt_t                pnt_prev_q;
  logic [PNT_W:0]      pnt_nxt;
  logic [PNT_W:0]      pnt_sub;
  logic                pnt_end;     // next step passes size
  logic [PIPE_LAT-2:0] play_sr_q;   // play_q delay line

  assign cont  = (burst_cfg_i.ncyc == '0) && (burst_cfg_i.rnum == '0);
  assign tick  = (tick_q == TICK_W'(TICK_CYCLES - 1));
  assign start = (!rep_q && trig_q) || (rep_q && (rep_cnt_q != '0) && (dly_q == '0));

  assign gate_drop = burst_cfg_i.rgate &&
                     ((!trig_ext_i && (burst_cfg_i.src == TRIG_EXT_POS)) ||
                      (trig_ext_i && (burst_cfg_i.src == TRIG_EXT_NEG)));

  // fixed point step, one guard bit for the end test
  assign pnt_nxt   = {1'b0, pnt_q} + {1'b0, burst_cfg_i.step};
  assign pnt_sub   = pnt_nxt - {1'b0, burst_cfg_i.size} - 1'b1;
  assign pnt_end   = ~pnt_sub[PNT_W];
  assign rd_addr_o = pnt_q[PNT_W-1:PNT_FRAC_W];  // integer part

  // ------------------------------------------------------------------
  // trigger, flags and counters
  // ------------------------------------------------------------------
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      trig_q      <= 1'b0;
      trig_done_o <= 1'b0;
      play_q      <= 1'b0;
      rep_q       <= 1'b0;
      start_q     <= 1'b0;
      tick_q      <= '0;
      cyc_q       <= '0;
      rep_cnt_q   <= '0;
      dly_q       <= '0;
      pnt_prev_q  <= '0;
    end else begin
      case (burst_cfg_i.src)
        TRIG_SW:      trig_q <= trig_sw_i;
        TRIG_EXT_POS: trig_q <= trig_pos_i;
        TRIG_EXT_NEG: trig_q <= trig_neg_i;
        default:      trig_q <= 1'b0;
      endcase
      trig_done_o <= !rep_q && trig_q;

      // 1 us tick, held in reset while playing
      if (play_q || tick) tick_q <= '0;
      else                tick_q <= tick_q + 1'b1;

      // delay between repetitions
      if (burst_cfg_i.rst || play_q) begin
        dly_q <= burst_cfg_i.rdly;
      end else if ((dly_q != '0) && tick) begin
        dly_q <= dly_q - 1'b1;
      end

      if (trig_q && !play_q) begin
        rep_cnt_q <= burst_cfg_i.rnum;
      end else if (!burst_cfg_i.rgate && (rep_cnt_q != '0) && rep_q && start && !play_q) begin
        rep_cnt_q <= rep_cnt_q - 1'b1;
      end else if (gate_drop) begin
        rep_cnt_q <= '0;
      end

      // table cycles, counted on pointer wrap-around
      pnt_prev_q <= pnt_q;
      start_q    <= start;
      if (start) begin
        cyc_q <= burst_cfg_i.ncyc;
      end else if (!start_q && (cyc_q != '0) && (pnt_prev_q > pnt_q)) begin
        cyc_q <= cyc_q - 1'b1;
      end

      if (start && !burst_cfg_i.rst) begin
        play_q <= 1'b1;
      end else if (burst_cfg_i.rst || ((cyc_q == 16'd1) && pnt_end)) begin
        play_q <= 1'b0;
      end

      if (start && !burst_cfg_i.rst) begin
        rep_q <= 1'b1;
      end else if (burst_cfg_i.rst || (rep_cnt_q == '0)) begin
        rep_q <= 1'b0;
      end
    end
  end

  // read pointer
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      pnt_q <= '0;
    end else if (burst_cfg_i.rst || (start && !play_q)) begin
      pnt_q <= burst_cfg_i.ofs;  // manual reset or burst start
    end else if (play_q) begin
      if (pnt_end) pnt_q <= burst_cfg_i.wrap ? pnt_sub[PNT_W-1:0] : burst_cfg_i.ofs;
      else         pnt_q <= pnt_nxt[PNT_W-1:0];
    end
  end

  // ------------------------------------------------------------------
  // last value hold, aligned to the sample pipeline
  // ------------------------------------------------------------------
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      play_sr_q   <= '0;
      hold_last_o <= 1'b0;
    end else begin
      play_sr_q <= {play_sr_q[PIPE_LAT-3:0], play_q};
      if (play_sr_q[PIPE_LAT-2 -: 2] == 2'b10) begin
        hold_last_o <= 1'b1;  // play dropped 4 cycles ago
      end
      // released by the next repetition, a reset or continuous mode
      if ((hold_last_o && (dly_q == '0) && (rep_cnt_q != '0)) || burst_cfg_i.rst || cont) begin
        hold_last_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/asg_ext_trig.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_ext_trig import asg_pkg::*; (
  input  wire  dac_clk_i,
  input  wire  dac_rstn_i,
  input  wire  trig_ext_i,   // async pin
  output logic trig_pos_o,
  output logic trig_neg_o
);

  logic [2:0]       sync_q;      // [1:0] synchronizer, [2] previous level
  logic [1:0]       chg;         // 0 rising, 1 falling
  logic [DEB_W-1:0] deb_q [2];   // hold-off counters
  logic [1:0]       hist_q [2];  // debounced level history

  assign chg[0] = sync_q[1] & ~sync_q[2];
  assign chg[1] = ~sync_q[1] & sync_q[2];

  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      sync_q <= '0;
      for (int i = 0; i < 2; i++) begin
        deb_q[i]  <= '0;
        hist_q[i] <= '0;
      end
    end else begin
      sync_q <= {sync_q[1:0], trig_ext_i};
      for (int i = 0; i < 2; i++) begin
        // start hold-off on a fresh change
        if ((deb_q[i] == '0) && chg[i]) begin
          deb_q[i] <= DEB_W'(DEBOUNCE_CYCLES);
        end else if (deb_q[i] != '0) begin
          deb_q[i] <= deb_q[i] - 1'b1;
        end
        hist_q[i][1] <= hist_q[i][0];
        if (deb_q[i] == '0) begin
          hist_q[i][0] <= sync_q[1];  // frozen while counting
        end
      end
    end
  end

  assign trig_pos_o = (hist_q[0] == 2'b01);
  assign trig_neg_o = (hist_q[1] == 2'b10);

endmodule

`default_nettype wire

/* hw/asg_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module asg_apb_regs import asg_pkg::*, asg_apb_pkg::*; (
  input  wire        dac_clk_i,
  input  wire        dac_rstn_i,
  input  wire  apb_req_t   apb_req_i,
  output apb_rsp_t   apb_rsp_o,
  output burst_cfg_t burst_cfg_o,
  output out_cfg_t   out_cfg_o,
  output logic       trig_sw_o,   // one cycle pulse
  output tbl_wr_t    tbl_wr_o
);

  logic              access;   // second phase of a transfer
  logic              wr;
  logic              tbl_hit;
  logic              hit;      // offset is mapped
  apb_addr_t         addr;
  logic [APB_DW-1:0] wdata;
  logic [APB_DW-1:0] rdata;
  burst_cfg_t        burst_q;
  out_cfg_t          out_q;
  logic              sw_q;
  logic              tbl_we_q;
  logic [TBL_AW-1:0] tbl_addr_q;
  sample_t           tbl_data_q;

  assign addr    = apb_req_i.paddr;
  assign wdata   = apb_req_i.pwdata;
  assign access  = apb_req_i.psel & apb_req_i.penable;
  assign wr      = access & apb_req_i.pwrite;
  assign tbl_hit = (addr >= TBL_BASE) && (addr < TBL_BASE + TBL_SPAN);

  // ------------------------------------------------------------------
  // register writes, end of access cycle
  // ------------------------------------------------------------------
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      burst_q <= '0;
      out_q   <= '0;
      sw_q    <= 1'b0;
    end else begin
      sw_q <= 1'b0;  // self clearing
      if (wr) begin
        case (addr)
          REG_CTRL: begin
            burst_q.rst   <= wdata[0];
            burst_q.wrap  <= wdata[1];
            out_q.zero    <= wdata[2];
            burst_q.rgate <= wdata[3];
            burst_q.src   <= trig_src_e'(wdata[6:4]);
            sw_q          <= wdata[7];   // sw trigger
          end
          REG_AMP_DC: begin
            out_q.amp <= wdata[SAMPLE_W-1:0];
            out_q.dc  <= wdata[16 +: SAMPLE_W];
          end
          REG_SIZE: burst_q.size <= wdata[PNT_W-1:0];
          REG_OFS:  burst_q.ofs  <= wdata[PNT_W-1:0];
          REG_STEP: burst_q.step <= wdata[PNT_W-1:0];
          REG_LAST: out_q.last   <= wdata[SAMPLE_W-1:0];
          REG_NCYC: burst_q.ncyc <= wdata[15:0];
          REG_RNUM: burst_q.rnum <= wdata[15:0];
          REG_RDLY: burst_q.rdly <= wdata;
          default: ;
        endcase
      end
    end
  end

  // table beats
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      tbl_we_q <= 1'b0;
    end else begin
      tbl_we_q <= wr & tbl_hit;
    end
  end

  always_ff @(posedge dac_clk_i) begin
    tbl_addr_q <= addr[TBL_AW+1:2];  // word index
    tbl_data_q <= wdata[SAMPLE_W-1:0];
  end

  // ------------------------------------------------------------------
  // read back, combinational during access
  // ------------------------------------------------------------------
  always_comb begin
    rdata = '0;
    hit   = 1'b1;
    case (addr)
      REG_CTRL:   rdata[6:0] = {burst_q.src, burst_q.rgate, out_q.zero,
                                burst_q.wrap, burst_q.rst};  // bit 7 reads 0
      REG_AMP_DC: begin
        rdata[SAMPLE_W-1:0]    = out_q.amp;
        rdata[16 +: SAMPLE_W]  = out_q.dc;
      end
      REG_SIZE:   rdata[PNT_W-1:0]    = burst_q.size;
      REG_OFS:    rdata[PNT_W-1:0]    = burst_q.ofs;
      REG_STEP:   rdata[PNT_W-1:0]    = burst_q.step;
      REG_LAST:   rdata[SAMPLE_W-1:0] = out_q.last;
      REG_NCYC:   rdata[15:0]         = burst_q.ncyc;
      REG_RNUM:   rdata[15:0]         = burst_q.rnum;
      REG_RDLY:   rdata               = burst_q.rdly;
      default:    hit = tbl_hit;  // table is write only, reads 0
    endcase
  end

  assign apb_rsp_o   = '{prdata: rdata, pslverr: access & ~hit};
  assign burst_cfg_o = burst_q;
  assign out_cfg_o   = out_q;
  assign trig_sw_o   = sw_q;
  assign tbl_wr_o    = '{we: tbl_we_q, addr: tbl_addr_q, data: tbl_data_q};

endmodule

`default_nettype wire

/* hw/asg_apb_pkg.sv */
`default_nettype none

package asg_apb_pkg;

  localparam int unsigned APB_AW = 20;
  localparam int unsigned APB_DW = 32;

  typedef logic [APB_AW-1:0] apb_addr_t;

  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_AW-1:0] paddr;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  // no pready, slave is always ready
  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pslverr;
  } apb_rsp_t;

  // ------------------------------------------------------------------
  // register map
  // ------------------------------------------------------------------
  localparam apb_addr_t REG_CTRL   = 20'h00;
  localparam apb_addr_t REG_AMP_DC = 20'h04;
  localparam apb_addr_t REG_SIZE   = 20'h08;
  localparam apb_addr_t REG_OFS    = 20'h0c;
  localparam apb_addr_t REG_STEP   = 20'h10;
  localparam apb_addr_t REG_LAST   = 20'h14;
  localparam apb_addr_t REG_NCYC   = 20'h18;
  localparam apb_addr_t REG_RNUM   = 20'h1c;
  localparam apb_addr_t REG_RDLY   = 20'h20;

  localparam apb_addr_t TBL_BASE = 20'h10000;  // sample n at TBL_BASE + 4*n
  localparam apb_addr_t TBL_SPAN = 20'h01000;  // 1024 words of 4 bytes

endpackage

`default_nettype wire

/* hw/asg_pkg.sv */
`default_nettype none

package asg_pkg;

  // ------------------------------------------------------------------
  // widths
  // ------------------------------------------------------------------
  localparam int unsigned SAMPLE_W   = 14;                  // dac word
  localparam int unsigned TBL_AW     = 10;                  // 1024 samples
  localparam int unsigned PNT_FRAC_W = 16;                  // pointer fraction
  localparam int unsigned PNT_W      = TBL_AW + PNT_FRAC_W;

  // timing constants, 125 MHz dac clock
  localparam int unsigned TICK_CYCLES     = 125;    // 1 us delay tick
  localparam int unsigned TICK_W          = $clog2(TICK_CYCLES);
  localparam int unsigned DEBOUNCE_CYCLES = 62500;  // ~0.5 ms
  localparam int unsigned DEB_W           = $clog2(DEBOUNCE_CYCLES + 1);
  localparam int unsigned PIPE_LAT        = 5;      // pointer reg to dac_o

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic [PNT_W-1:0]           pnt_t;    // table index . fraction
  typedef logic [15:0]                cnt16_t;
  typedef logic [31:0]                dly_t;    // in us ticks

  typedef enum logic [2:0] {
    TRIG_NONE    = 3'd0,
    TRIG_SW      = 3'd1,
    TRIG_EXT_POS = 3'd2,  // debounced rising edge
    TRIG_EXT_NEG = 3'd3   // debounced falling edge
  } trig_src_e;

  typedef struct packed {
    pnt_t      size;   // last pointer value of the table
    pnt_t      step;
    pnt_t      ofs;    // restart point
    logic      wrap;
    logic      rst;
    logic      rgate;  // repetition gated by ext level
    cnt16_t    ncyc;
    cnt16_t    rnum;
    dly_t      rdly;
    trig_src_e src;
  } burst_cfg_t;

  typedef struct packed {
    logic [SAMPLE_W-1:0] amp;  // unsigned, 0x2000 is unity
    sample_t             dc;
    sample_t             last;
    logic                zero;
  } out_cfg_t;

  typedef struct packed {
    logic              we;
    logic [TBL_AW-1:0] addr;
    sample_t           data;
  } tbl_wr_t;

endpackage

`default_nettype wire
